// ==== files.f ====
rtl/colmix_video_pkg.sv
rtl/colmix_pal_pkg.sv
rtl/colmix_pixel_if.sv
rtl/colmix_layer_prio.sv
rtl/colmix_palette.sv
rtl/colmix_brightness.sv
rtl/colmix_top.sv
tb/tb_colmix_top.sv

// ==== tb/tb_colmix_top.sv ====
/*
 * testbench for the colour mixer
 * palette model, reference mixer and queued checks across the 3-strobe pipeline
 */
`timescale 1ns/1ps
`default_nettype none

module tb_colmix_top;
    import colmix_video_pkg::*;
    import colmix_pal_pkg::*;

    localparam int MODE_RANDOM = 0;
    localparam int MODE_SCR1   = 1;
    localparam int MODE_SCR2   = 2;
    localparam int MODE_SCR3   = 3;
    localparam int MODE_BLANK  = 4;

    logic       clk;
    logic       rst;
    logic       pxl_cen;
    logic       hb;
    logic       vb;
    layer_pxl_t scr1_pxl;
    layer_pxl_t scr2_pxl;
    layer_pxl_t scr3_pxl;
    logic       pal_we;
    pal_addr_t  pal_waddr;
    pal_entry_t pal_wdata;
    rgb5_t      red;
    rgb5_t      green;
    rgb5_t      blue;

    // palette as the testbench believes it to be
    pal_entry_t  pal_model [0:4095];
    // expected {red, green, blue} pushed as each pixel is driven
    logic [14:0] exp_q [$];
    logic [14:0] exp_rgb;
    logic [31:0] lcg_state = 32'h76ae57ef;
    logic [15:0] bright_seen = '0;
    int          errors = 0;
    int          checks = 0;

    colmix_top u_colmix_top (
        .clk       (clk),
        .rst       (rst),
        .pxl_cen   (pxl_cen),
        .hb        (hb),
        .vb        (vb),
        .scr1_pxl  (scr1_pxl),
        .scr2_pxl  (scr2_pxl),
        .scr3_pxl  (scr3_pxl),
        .pal_we    (pal_we),
        .pal_waddr (pal_waddr),
        .pal_wdata (pal_wdata),
        .red       (red),
        .green     (green),
        .blue      (blue)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    function automatic logic [31:0] lcg_next();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    // pen 15 about half the time so every priority case shows up
    function automatic layer_pxl_t random_pixel();
        logic [31:0] r;
        r = lcg_next();
        return {r[31:27], r[26] ? 4'hf : r[25:22]};
    endfunction

    function automatic layer_pxl_t opaque_pixel();
        logic [31:0] r;
        logic [3:0]  pen;
        r = lcg_next();
        pen = r[23:20];
        if (pen == 4'hf) begin
            pen = 4'h0;
        end
        return {r[31:27], pen};
    endfunction

    // scroll 1 over 2 over 3 with scroll 3 as the backdrop
    function automatic pal_addr_t visible_addr(input layer_pxl_t p1, input layer_pxl_t p2,
                                               input layer_pxl_t p3);
        if (p1[3:0] != 4'hf) begin
            return {3'd1, p1};
        end
        if (p2[3:0] != 4'hf) begin
            return {3'd2, p2};
        end
        return {3'd3, p3};
    endfunction

    // expected colour with each channel c * (b + 16) / 16
    function automatic logic [14:0] expected_rgb(input layer_pxl_t p1, input layer_pxl_t p2,
                                                 input layer_pxl_t p3, input logic blank);
        pal_entry_t w;
        int         b;
        int         r;
        int         g;
        int         bl;
        if (blank) begin
            return 15'd0;
        end
        w  = pal_model[visible_addr(p1, p2, p3)];
        b  = w[15:12];
        r  = (int'(w[11:8]) * (b + 16)) / 16;
        g  = (int'(w[7:4]) * (b + 16)) / 16;
        bl = (int'(w[3:0]) * (b + 16)) / 16;
        return {r[4:0], g[4:0], bl[4:0]};
    endfunction

    task automatic check_channel(input string name, input rgb5_t got, input rgb5_t exp);
        checks++;
        assert (got === exp) else begin
            errors++;
            $display("Fail %s: got 0x%h, expected 0x%h at %0t", name, got, exp, $time);
        end
    endtask

    // one pixel with the strobe on this cycle and quiet on the next
    task automatic drive_pixel(input layer_pxl_t p1, input layer_pxl_t p2,
                               input layer_pxl_t p3, input logic h, input logic v);
        @(posedge clk);
        #2;
        pxl_cen  = 1'b1;
        scr1_pxl = p1;
        scr2_pxl = p2;
        scr3_pxl = p3;
        hb       = h;
        vb       = v;
        exp_q.push_back(expected_rgb(p1, p2, p3, h | v));
        if (!(h | v)) begin
            bright_seen[pal_model[visible_addr(p1, p2, p3)][15:12]] = 1'b1;
        end
        @(posedge clk);
        #2;
        pxl_cen = 1'b0;
    endtask

    // CPU write with the model following at once
    task automatic write_palette(input pal_addr_t addr, input pal_entry_t data);
        @(posedge clk);
        #2;
        pal_we    = 1'b1;
        pal_waddr = addr;
        pal_wdata = data;
        pal_model[addr] = data;
        @(posedge clk);
        #2;
        pal_we = 1'b0;
    endtask

    // two blanked pixels push the last real ones out
    // the blanked ones stay in flight and do not care about palette changes
    task automatic flush_pipeline();
        for (int i = 0; i < 2; i++) begin
            drive_pixel('0, '0, '0, 1'b1, 1'b0);
        end
    endtask

    task automatic run_pixels(input int mode, input int count);
        layer_pxl_t  p1;
        layer_pxl_t  p2;
        layer_pxl_t  p3;
        logic        h;
        logic        v;
        logic [31:0] r;
        for (int i = 0; i < count; i++) begin
            p1 = random_pixel();
            p2 = random_pixel();
            p3 = random_pixel();
            r  = lcg_next();
            h  = (r[31:28] == 4'h0);
            v  = (r[27:24] == 4'h0);
            case (mode)
                MODE_SCR1: begin
                    p1 = opaque_pixel();
                    h  = 1'b0;
                    v  = 1'b0;
                end
                MODE_SCR2: begin
                    p1[3:0] = 4'hf;
                    p2 = opaque_pixel();
                    h  = 1'b0;
                    v  = 1'b0;
                end
                MODE_SCR3: begin
                    // scroll 3 pen left random with 15 included
                    p1[3:0] = 4'hf;
                    p2[3:0] = 4'hf;
                    h  = 1'b0;
                    v  = 1'b0;
                end
                MODE_BLANK: begin
                    h = r[0];
                    v = ~r[0] | r[1];
                end
                default: begin
                end
            endcase
            drive_pixel(p1, p2, p3, h, v);
        end
        flush_pipeline();
    endtask

    // output after strobe N+2 belongs to the pixel driven for strobe N
    always @(posedge clk) begin
        if (!rst && pxl_cen) begin
            #1;
            if (exp_q.size() >= 3) begin
                exp_rgb = exp_q.pop_front();
            end else begin
                // black while the pipeline still fills from reset
                exp_rgb = 15'd0;
            end
            check_channel("red", red, exp_rgb[14:10]);
            check_channel("green", green, exp_rgb[9:5]);
            check_channel("blue", blue, exp_rgb[4:0]);
        end
    end

    initial begin
        logic [31:0] r;
        pal_addr_t   a;
        rst       = 1'b1;
        pxl_cen   = 1'b0;
        hb        = 1'b0;
        vb        = 1'b0;
        scr1_pxl  = '0;
        scr2_pxl  = '0;
        scr3_pxl  = '0;
        pal_we    = 1'b0;
        pal_waddr = '0;
        pal_wdata = '0;
        repeat (4) @(posedge clk);
        #2;
        rst = 1'b0;
        check_channel("red", red, 5'd0);
        check_channel("green", green, 5'd0);
        check_channel("blue", blue, 5'd0);

        // whole palette loaded with random words
        for (int i = 0; i < 4096; i++) begin
            r = lcg_next();
            write_palette(i[11:0], r[31:16]);
        end
        // no strobe yet so still black
        check_channel("red", red, 5'd0);
        check_channel("green", green, 5'd0);
        check_channel("blue", blue, 5'd0);

        run_pixels(MODE_SCR1, 40);
        run_pixels(MODE_SCR2, 40);
        run_pixels(MODE_SCR3, 40);
        run_pixels(MODE_BLANK, 40);
        run_pixels(MODE_RANDOM, 400);

        // same pixel before and after a rewrite of its entry
        a = {LAYER_SCR1, 9'h0a3};
        write_palette(a, 16'h5c3a);
        drive_pixel(9'h0a3, 9'h111, 9'h022, 1'b0, 1'b0);
        flush_pipeline();
        write_palette(a, 16'hf8e1);
        drive_pixel(9'h0a3, 9'h111, 9'h022, 1'b0, 1'b0);
        flush_pipeline();

        // scattered rewrites inside the three layer banks
        for (int i = 0; i < 256; i++) begin
            r = lcg_next();
            a = {(r[10:9] == 2'd0) ? 3'd1 : {1'b0, r[10:9]}, r[8:0]};
            write_palette(a, r[31:16]);
        end
        run_pixels(MODE_RANDOM, 400);

        assert (bright_seen == 16'hffff) else begin
            errors++;
            $display("not every brightness value reached the outputs, seen mask 0x%h",
                     bright_seen);
        end

        $display("checks %0d, errors %0d", checks, errors);
        if (errors == 0) begin
            $display("TEST PASS");
        end else begin
            $display("TEST FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== rtl/colmix_top.sv ====
/*
 * colour mixer top level
 * priority, palette lookup and brightness in a 3-strobe pipeline
 */
`timescale 1ns/1ps
`default_nettype none

module colmix_top (
    input  wire                          clk,
    input  wire                          rst,
    // pipeline step, one clk wide
    input  wire                          pxl_cen,
    // blanking
    input  wire                          hb,
    input  wire                          vb,
    // scroll layer pixels
    input  wire colmix_video_pkg::layer_pxl_t scr1_pxl,
    input  wire colmix_video_pkg::layer_pxl_t scr2_pxl,
    input  wire colmix_video_pkg::layer_pxl_t scr3_pxl,
    // cpu palette write port
    input  wire                          pal_we,
    input  wire colmix_video_pkg::pal_addr_t  pal_waddr,
    input  wire colmix_pal_pkg::pal_entry_t   pal_wdata,
    // video out
    output colmix_video_pkg::rgb5_t      red,
    output colmix_video_pkg::rgb5_t      green,
    output colmix_video_pkg::rgb5_t      blue
);

    // priority -> palette
    colmix_pixel_if prio_bus ();
    // palette -> brightness
    colmix_pixel_if pal_bus ();

    // stage 1, pick the visible layer
    colmix_layer_prio u_prio (
        .clk      (clk),
        .rst      (rst),
        .pxl_cen  (pxl_cen),
        .hb       (hb),
        .vb       (vb),
        .scr1_pxl (scr1_pxl),
        .scr2_pxl (scr2_pxl),
        .scr3_pxl (scr3_pxl),
        .prio     (prio_bus.src)
    );

    // stage 2, palette RAM read
    colmix_palette u_pal (
        .clk       (clk),
        .rst       (rst),
        .pxl_cen   (pxl_cen),
        .pal_we    (pal_we),
        .pal_waddr (pal_waddr),
        .pal_wdata (pal_wdata),
        .prio      (prio_bus.dst),
        .pal       (pal_bus.src)
    );

    // stage 3, brightness and blanking
    colmix_brightness u_bright (
        .clk     (clk),
        .rst     (rst),
        .pxl_cen (pxl_cen),
        .pal     (pal_bus.dst),
        .red     (red),
        .green   (green),
        .blue    (blue)
    );

endmodule

`default_nettype wire

// ==== rtl/colmix_brightness.sv ====
/*
 * brightness stage of the colour mixer
 * scales each colour nibble by the entry brightness, blanks to black
 */
`timescale 1ns/1ps
`default_nettype none

module colmix_brightness (
    input  wire                     clk,
    input  wire                     rst,
    input  wire                     pxl_cen,
    colmix_pixel_if.dst             pal,
    output colmix_video_pkg::rgb5_t red,
    output colmix_video_pkg::rgb5_t green,
    output colmix_video_pkg::rgb5_t blue
);
    import colmix_video_pkg::*;
    import colmix_pal_pkg::*;

    // c * (b + 16) / 16, b + 16 is just b with a 1 on top
    // largest value 15 * 31 / 16 = 29
    function automatic rgb5_t scale(input nibble_t c, input nibble_t b);
        logic [8:0] prod;
        prod = {5'd0, c} * {4'd0, 1'b1, b};
        return prod[8:4];
    endfunction

    nibble_t bright;
    rgb5_t   red_d;
    rgb5_t   green_d;
    rgb5_t   blue_d;

    assign bright  = pal_bright(pal.entry);
    assign red_d   = scale(pal_red(pal.entry), bright);
    assign green_d = scale(pal_green(pal.entry), bright);
    assign blue_d  = scale(pal_blue(pal.entry), bright);

    // output registers, black out of reset and during blanking
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            red   <= '0;
            green <= '0;
            blue  <= '0;
        end else if (pxl_cen) begin
            if (pal.blank) begin
                red   <= '0;
                green <= '0;
                blue  <= '0;
            end else begin
                red   <= red_d;
                green <= green_d;
                blue  <= blue_d;
            end
        end
    end

endmodule

`default_nettype wire

// ==== rtl/colmix_palette.sv ====
/*
 * palette lookup stage of the colour mixer
 * 4096 x 16 RAM, CPU write port and a registered pixel read
 */
`timescale 1ns/1ps
`default_nettype none

module colmix_palette (
    input  wire                          clk,
    input  wire                          rst,
    input  wire                          pxl_cen,
    input  wire                          pal_we,
    input  wire colmix_video_pkg::pal_addr_t  pal_waddr,
    input  wire colmix_pal_pkg::pal_entry_t   pal_wdata,
    colmix_pixel_if.dst                  prio,
    colmix_pixel_if.src                  pal
);
    import colmix_video_pkg::*;
    import colmix_pal_pkg::*;

    // one word per address, whole address space
    localparam int PAL_WORDS = 2 ** $bits(pal_addr_t);

    pal_entry_t mem [0:PAL_WORDS-1];
    pal_entry_t rd_q;
    logic       blank_q;

    // cpu side writes on the strobe cycle
    // pixel side reads only when the pipeline steps
    // same address both sides in one cycle gives an undefined read
    always_ff @(posedge clk) begin
        if (pal_we) begin
            mem[pal_waddr] <= pal_wdata;
        end
        if (pxl_cen) begin
            rd_q <= mem[prio.pal_addr];
        end
    end

    // blank follows the pixel by one strobe
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            blank_q <= 1'b1;
        end else if (pxl_cen) begin
            blank_q <= prio.blank;
        end
    end

    assign pal.entry    = rd_q;
    assign pal.blank    = blank_q;
    // address is spent once the word is read
    assign pal.pal_addr = '0;

endmodule

`default_nettype wire

// ==== rtl/colmix_layer_prio.sv ====
/*
 * layer priority stage of the colour mixer
 * scroll 1 over scroll 2 over scroll 3, pen 15 is see-through
 */
`timescale 1ns/1ps
`default_nettype none

module colmix_layer_prio (
    input  wire                          clk,
    input  wire                          rst,
    input  wire                          pxl_cen,
    input  wire                          hb,
    input  wire                          vb,
    input  wire colmix_video_pkg::layer_pxl_t scr1_pxl,
    input  wire colmix_video_pkg::layer_pxl_t scr2_pxl,
    input  wire colmix_video_pkg::layer_pxl_t scr3_pxl,
    colmix_pixel_if.src                  prio
);
    import colmix_video_pkg::*;

    layer_pxl_t sel_pxl;
    layer_id_t  sel_id;
    pal_addr_t  addr_q;
    logic       blank_q;

    // first opaque layer wins
    // scroll 3 is the backdrop, shown even when its own pen is clear
    always_comb begin
        if (scr1_pxl[3:0] != TRANSP_PEN) begin
            sel_pxl = scr1_pxl;
            sel_id  = LAYER_SCR1;
        end else if (scr2_pxl[3:0] != TRANSP_PEN) begin
            sel_pxl = scr2_pxl;
            sel_id  = LAYER_SCR2;
        end else begin
            sel_pxl = scr3_pxl;
            sel_id  = LAYER_SCR3;
        end
    end

    // address register, payload only
    always_ff @(posedge clk) begin
        if (pxl_cen) begin
            addr_q <= {sel_id, sel_pxl};
        end
    end

    // blank comes out of reset set so the screen starts black
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            blank_q <= 1'b1;
        end else if (pxl_cen) begin
            blank_q <= hb | vb;
        end
    end

    assign prio.pal_addr = addr_q;
    assign prio.blank    = blank_q;
    // no palette word yet at this stage
    assign prio.entry    = '0;

endmodule

`default_nettype wire

// ==== rtl/colmix_pixel_if.sv ====
/*
 * pixel hand-off between two mixer pipeline stages
 * address, palette word and blanking flag of one pixel
 */
`timescale 1ns/1ps
`default_nettype none

interface colmix_pixel_if;
    import colmix_video_pkg::*;
    import colmix_pal_pkg::*;

    // palette address, used by the lookup stage
    pal_addr_t  pal_addr;
    // palette word, only valid after the lookup
    pal_entry_t entry;
    // force black for this pixel
    logic       blank;

    // producing stage
    modport src (
        output pal_addr,
        output entry,
        output blank
    );

    // consuming stage
    modport dst (
        input pal_addr,
        input entry,
        input blank
    );

endinterface

`default_nettype wire

// ==== rtl/colmix_pal_pkg.sv ====
/*
 * palette word layout
 * brightness, red, green and blue nibbles from msb down
 */
`default_nettype none

package colmix_pal_pkg;

    typedef logic [15:0] pal_entry_t;
    typedef logic [3:0]  nibble_t;

    // field pickers, brightness on top
    function automatic nibble_t pal_bright(input pal_entry_t e);
        return e[15:12];
    endfunction

    function automatic nibble_t pal_red(input pal_entry_t e);
        return e[11:8];
    endfunction

    function automatic nibble_t pal_green(input pal_entry_t e);
        return e[7:4];
    endfunction

    function automatic nibble_t pal_blue(input pal_entry_t e);
        return e[3:0];
    endfunction

endpackage

`default_nettype wire

// ==== rtl/colmix_video_pkg.sv ====
/*
 * colour mixer video types
 * scroll layer pixels, layer codes, palette addresses and output colour
 */
`default_nettype none

package colmix_video_pkg;

    // scroll pixel, palette select in [8:4], pen in [3:0]
    typedef logic [8:0] layer_pxl_t;

    // layer code, top bits of the palette address
    typedef logic [2:0] layer_id_t;

    localparam layer_id_t LAYER_SCR1 = 3'd1;
    localparam layer_id_t LAYER_SCR2 = 3'd2;
    localparam layer_id_t LAYER_SCR3 = 3'd3;

    // {layer code, chosen pixel}
    typedef logic [11:0] pal_addr_t;

    // pen value that lets the layer below show through
    localparam logic [3:0] TRANSP_PEN = 4'hf;

    // one 5-bit colour channel on the video output
    typedef logic [4:0] rgb5_t;

endpackage

`default_nettype wire
